// ==== include/femtosoc_settings.svh ====
// project-wide widths; RAM depth must be a power of two and the IO page bit must sit above the RAM
`ifndef FEMTOSOC_SETTINGS_SVH
`define FEMTOSOC_SETTINGS_SVH

// processor byte address
`define FEMTOSOC_ADDR_W 24

// RAM depth in 32-bit words, word address taken from addr[11:2]
`define FEMTOSOC_RAM_WORDS 1024

// address bit that moves an access from RAM to the IO page
`define FEMTOSOC_IO_PAGE_BIT 22

// one-hot IO register select, byte address bits 12..2
`define FEMTOSOC_IO_ADDR_W 11

// led matrix bit clock divider, 3 bits gives clk/8
`define FEMTOSOC_LEDMTX_DIV_W 3

// flash byte address sent after the read opcode
`define FEMTOSOC_FLASH_ADDR_W 24

`endif

// ==== source/soc_bus_pkg.sv ====
// bus structs only; a write is any nonzero wmask, a read is a one-cycle rstrb pulse
`include "femtosoc_settings.svh"

package soc_bus_pkg;

  // processor side request
  typedef struct packed {
    logic [`FEMTOSOC_ADDR_W-1:0] addr;
    logic [31:0]                 wdata;
    logic [3:0]                  wmask;  // one bit per byte lane
    logic                        rstrb;
  } mem_req_t;

  // response back to the processor
  typedef struct packed {
    logic [31:0] rdata;
    logic        rbusy;
    logic        wbusy;
  } mem_rsp_t;

  // request to the IO page, strobes already qualified by the page bit
  typedef struct packed {
    logic [`FEMTOSOC_IO_ADDR_W-1:0] sel;  // one-hot register select
    logic [31:0]                    wdata;
    logic                           wr;
    logic                           rd;
  } io_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        rbusy;  // flash byte still arriving
    logic        wbusy;  // a serial device is still sending
  } io_rsp_t;

endpackage

// ==== source/soc_io_pkg.sv ====
// IO register positions and device encodings; unlisted select bits are reserved and read as zero
package soc_io_pkg;

  // bit positions inside the one-hot IO select
  typedef enum logic [3:0] {
    IO_LEDS        = 4'd0,   // rw, leds in bits 3..0
    IO_LEDMTX_CNTL = 4'd6,   // r, matrix busy in bit 0
    IO_LEDMTX_DAT  = 4'd7,   // w, 16-bit matrix frame
    IO_SPI_FLASH   = 4'd8,   // w address, r byte plus busy in bit 8
    IO_BUTTONS     = 4'd10   // r, buttons in bits 5..0
  } io_reg_e;

  typedef enum logic {
    LEDMTX_IDLE,
    LEDMTX_SEND
  } ledmtx_state_e;

  typedef enum logic [1:0] {
    FLASH_IDLE,
    FLASH_SEND,   // opcode and address out on mosi
    FLASH_RECV    // data byte in on miso
  } flash_state_e;

  // plain read command, no dummy cycles
  typedef enum logic [7:0] {
    FLASH_READ = 8'h03
  } flash_opcode_e;

endpackage

// ==== source/femtosoc_memory.sv ====
// RAM never stalls and starts undefined; addresses alias above the RAM size; addr must be held after a read
`include "femtosoc_settings.svh"

module femtosoc_memory (
  input  logic                  clk,
  input  logic                  RESET,
  input  soc_bus_pkg::mem_req_t mem_req,
  output soc_bus_pkg::mem_rsp_t mem_rsp,
  output soc_bus_pkg::io_req_t  io_req,
  input  soc_bus_pkg::io_rsp_t  io_rsp
);

  localparam int WORD_AW = $clog2(`FEMTOSOC_RAM_WORDS);

  logic [31:0]        ram [`FEMTOSOC_RAM_WORDS];
  logic [31:0]        ram_rdata_q;
  logic [WORD_AW-1:0] word_addr;
  logic               is_io;
  logic               any_wr;
  logic               io_sel_q;  // last access went to the IO page

  assign is_io     = mem_req.addr[`FEMTOSOC_IO_PAGE_BIT];
  assign word_addr = mem_req.addr[WORD_AW+1:2];
  assign any_wr    = |mem_req.wmask;

  // byte-lane writes, read word registered every cycle
  always_ff @(posedge clk) begin
    if (any_wr && !is_io) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (mem_req.wmask[lane]) begin
          ram[word_addr][lane*8 +: 8] <= mem_req.wdata[lane*8 +: 8];
        end
      end
    end
    ram_rdata_q <= ram[word_addr];
  end

  // follows the page of the previous cycle, lines up with ram_rdata_q
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      io_sel_q <= 1'b0;
    end else begin
      io_sel_q <= is_io;
    end
  end

  always_comb begin
    io_req.sel   = mem_req.addr[`FEMTOSOC_IO_ADDR_W+1:2];
    io_req.wdata = mem_req.wdata;
    io_req.wr    = any_wr && is_io;
    io_req.rd    = mem_req.rstrb && is_io;
  end

  // IO data is combinational from the held address
  always_comb begin
    mem_rsp.rdata = io_sel_q ? io_rsp.rdata : ram_rdata_q;
    mem_rsp.rbusy = io_rsp.rbusy;
    mem_rsp.wbusy = io_rsp.wbusy;
  end

endmodule

// ==== source/led_matrix_tx.sv ====
// MAX7219 frames of 16 bits, MSB first; a load while busy restarts the frame
`include "femtosoc_settings.svh"

module led_matrix_tx (
  input  logic        clk,
  input  logic        RESET,
  input  logic        load,
  input  logic [15:0] word,
  output logic        busy,
  output logic        din,
  output logic        cs,
  output logic        sclk
);

  localparam logic [4:0] LEAD_IN = 5'd17;  // one idle divider period with cs low

  soc_io_pkg::ledmtx_state_e       state_q;
  logic [`FEMTOSOC_LEDMTX_DIV_W-1:0] div_q;
  logic [4:0]                      bitcnt_q;
  logic [15:0]                     shifter_q;
  logic                            tick;
  logic                            shifting;

  assign tick     = &div_q;  // last cycle of each bit period
  assign shifting = (state_q == soc_io_pkg::LEDMTX_SEND) && (bitcnt_q != LEAD_IN);

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state_q  <= soc_io_pkg::LEDMTX_IDLE;
      div_q    <= '0;
      bitcnt_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;  // free running
      if (load) begin
        state_q  <= soc_io_pkg::LEDMTX_SEND;
        bitcnt_q <= LEAD_IN;
      end else if (tick && state_q == soc_io_pkg::LEDMTX_SEND) begin
        bitcnt_q <= bitcnt_q - 1'b1;
        if (bitcnt_q == 5'd1) state_q <= soc_io_pkg::LEDMTX_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) shifter_q <= word;
    else if (tick && shifting) shifter_q <= {shifter_q[14:0], 1'b0};
  end

  assign busy = (state_q == soc_io_pkg::LEDMTX_SEND);
  assign cs   = !busy;
  assign din  = busy && shifter_q[15];
  assign sclk = shifting && div_q[`FEMTOSOC_LEDMTX_DIV_W-1];  // rises mid bit, din stable

endmodule

// ==== source/spi_flash_reader.sv ====
// one read in flight; miso is sampled at the clk edge that ends each sclk high phase
`include "femtosoc_settings.svh"

module spi_flash_reader (
  input  logic                              clk,
  input  logic                              RESET,
  input  logic                              start,
  input  logic [`FEMTOSOC_FLASH_ADDR_W-1:0] flash_addr,
  output logic                              busy,
  output logic                              receiving,
  output logic [7:0]                        data,
  output logic                              mosi,
  input  logic                              miso,
  output logic                              cs_n,
  output logic                              sclk
);

  localparam int CMD_W = $bits(soc_io_pkg::flash_opcode_e) + `FEMTOSOC_FLASH_ADDR_W;
  localparam int CNT_W = $clog2(CMD_W + 2);
  localparam logic [CNT_W-1:0] LEAD_IN = CNT_W'(CMD_W + 1);

  soc_io_pkg::flash_state_e state_q;
  logic                     slow_q;  // half-rate clock, free running
  logic [CNT_W-1:0]         bitcnt_q;
  logic [CMD_W-1:0]         cmd_q;
  logic [7:0]               data_q;
  logic                     sending;

  assign sending = (state_q == soc_io_pkg::FLASH_SEND) && (bitcnt_q != LEAD_IN);

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      state_q  <= soc_io_pkg::FLASH_IDLE;
      slow_q   <= 1'b0;
      bitcnt_q <= '0;
      data_q   <= '0;
      cs_n     <= 1'b1;
    end else begin
      slow_q <= ~slow_q;
      if (start) begin
        state_q  <= soc_io_pkg::FLASH_SEND;
        bitcnt_q <= LEAD_IN;
        cs_n     <= 1'b0;
      end else if (slow_q) begin
        unique case (state_q)
          soc_io_pkg::FLASH_IDLE: cs_n <= 1'b1;  // one slow phase after the last bit
          soc_io_pkg::FLASH_SEND: begin
            bitcnt_q <= bitcnt_q - 1'b1;
            if (bitcnt_q == CNT_W'(1)) begin
              state_q  <= soc_io_pkg::FLASH_RECV;
              bitcnt_q <= CNT_W'(8);
            end
          end
          soc_io_pkg::FLASH_RECV: begin
            bitcnt_q <= bitcnt_q - 1'b1;
            data_q   <= {data_q[6:0], miso};
            if (bitcnt_q == CNT_W'(1)) state_q <= soc_io_pkg::FLASH_IDLE;
          end
          default: state_q <= soc_io_pkg::FLASH_IDLE;
        endcase
      end
    end
  end

  // opcode then address, shifted at the end of each sclk high phase
  always_ff @(posedge clk) begin
    if (start) cmd_q <= {soc_io_pkg::FLASH_READ, flash_addr};
    else if (slow_q && sending) cmd_q <= {cmd_q[CMD_W-2:0], 1'b0};
  end

  assign busy      = (state_q != soc_io_pkg::FLASH_IDLE);
  assign receiving = (state_q == soc_io_pkg::FLASH_RECV);
  assign data      = data_q;
  assign mosi      = (state_q == soc_io_pkg::FLASH_SEND) && cmd_q[CMD_W-1];
  assign sclk      = slow_q && (sending || receiving);

endmodule

// ==== source/soc_io_page.sv ====
// sel must be one-hot; a write to a device that is still busy is undefined
`include "femtosoc_settings.svh"

module soc_io_page (
  input  logic                 clk,
  input  logic                 RESET,
  input  soc_bus_pkg::io_req_t io_req,
  output soc_bus_pkg::io_rsp_t io_rsp,
  output logic [3:0]           leds,
  input  logic [5:0]           buttons,
  output logic                 ledmtx_din,
  output logic                 ledmtx_cs,
  output logic                 ledmtx_clk,
  output logic                 spi_mosi,
  input  logic                 spi_miso,
  output logic                 spi_cs_n,
  output logic                 spi_clk
);

  logic       mtx_busy;
  logic       flash_busy;
  logic       flash_receiving;
  logic [7:0] flash_data;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= 4'b0;
    end else if (io_req.wr && io_req.sel[soc_io_pkg::IO_LEDS]) begin
      leds <= io_req.wdata[3:0];
    end
  end

  led_matrix_tx ledmtx_inst (
    .clk  (clk),
    .RESET(RESET),
    .load (io_req.wr && io_req.sel[soc_io_pkg::IO_LEDMTX_DAT]),
    .word (io_req.wdata[15:0]),
    .busy (mtx_busy),
    .din  (ledmtx_din),
    .cs   (ledmtx_cs),
    .sclk (ledmtx_clk)
  );

  spi_flash_reader flash_inst (
    .clk       (clk),
    .RESET     (RESET),
    .start     (io_req.wr && io_req.sel[soc_io_pkg::IO_SPI_FLASH]),
    .flash_addr(io_req.wdata[`FEMTOSOC_FLASH_ADDR_W-1:0]),
    .busy      (flash_busy),
    .receiving (flash_receiving),
    .data      (flash_data),
    .mosi      (spi_mosi),
    .miso      (spi_miso),
    .cs_n      (spi_cs_n),
    .sclk      (spi_clk)
  );

  // read data is the OR of every selected register
  always_comb begin
    io_rsp.rdata = 32'b0;
    if (io_req.sel[soc_io_pkg::IO_LEDS])        io_rsp.rdata |= {28'b0, leds};
    if (io_req.sel[soc_io_pkg::IO_LEDMTX_CNTL]) io_rsp.rdata |= {31'b0, mtx_busy};
    if (io_req.sel[soc_io_pkg::IO_SPI_FLASH]) begin
      io_rsp.rdata |= {23'b0, flash_busy, flash_data};
    end
    if (io_req.sel[soc_io_pkg::IO_BUTTONS])     io_rsp.rdata |= {26'b0, buttons};
    io_rsp.rbusy = flash_receiving;
    io_rsp.wbusy = mtx_busy | flash_busy;  // covers the whole flash transfer
  end

endmodule

// ==== source/femtosoc.sv ====
// bus side only; the processor port is driven from outside and follows the femtorv memory protocol
module femtosoc (
  input  logic                  clk,
  input  logic                  RESET,
  input  soc_bus_pkg::mem_req_t mem_req,
  output soc_bus_pkg::mem_rsp_t mem_rsp,
  output logic [3:0]            leds,
  input  logic [5:0]            buttons,
  output logic                  ledmtx_din,
  output logic                  ledmtx_cs,
  output logic                  ledmtx_clk,
  output logic                  spi_mosi,
  input  logic                  spi_miso,
  output logic                  spi_cs_n,
  output logic                  spi_clk
);

  soc_bus_pkg::io_req_t io_req;  // memory to IO page
  soc_bus_pkg::io_rsp_t io_rsp;

  femtosoc_memory memory_inst (
    .clk    (clk),
    .RESET  (RESET),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp),
    .io_req (io_req),
    .io_rsp (io_rsp)
  );

  soc_io_page io_page_inst (
    .clk       (clk),
    .RESET     (RESET),
    .io_req    (io_req),
    .io_rsp    (io_rsp),
    .leds      (leds),
    .buttons   (buttons),
    .ledmtx_din(ledmtx_din),
    .ledmtx_cs (ledmtx_cs),
    .ledmtx_clk(ledmtx_clk),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso),
    .spi_cs_n  (spi_cs_n),
    .spi_clk   (spi_clk)
  );

endmodule

// ==== test/femtosoc_properties.sv ====
// bound into femtosoc; checks reset state, serial clock gating and wbusy against the chip selects
module femtosoc_properties (
  input logic                  clk,
  input logic                  RESET,
  input soc_bus_pkg::mem_rsp_t mem_rsp,
  input logic [3:0]            leds,
  input logic                  ledmtx_cs,
  input logic                  ledmtx_clk,
  input logic                  spi_cs_n,
  input logic                  spi_clk
);
  timeunit 1ns;
  timeprecision 1ns;

  int assert_fails = 0;  // failed assertion count

  reset_outputs_idle: assert property (@(posedge clk) $rose(RESET) |-> leds == 4'b0 && ledmtx_cs
    && !ledmtx_clk && spi_cs_n && !spi_clk && !mem_rsp.rbusy && !mem_rsp.wbusy)
    else begin
      $error("outputs not inactive after reset");
      assert_fails++;
    end

  mtx_clk_gated: assert property (@(posedge clk) disable iff (!RESET) ledmtx_clk |-> !ledmtx_cs)
    else begin
      $error("ledmtx_clk high with ledmtx_cs high");
      assert_fails++;
    end
  spi_clk_gated: assert property (@(posedge clk) disable iff (!RESET) spi_clk |-> !spi_cs_n)
    else begin
      $error("spi_clk high with spi_cs_n high");
      assert_fails++;
    end

  // matrix busy is exactly cs low, flash busy ends before cs_n rises
  mtx_sets_wbusy: assert property (@(posedge clk) disable iff (!RESET)
    !ledmtx_cs |-> mem_rsp.wbusy)
    else begin
      $error("wbusy low during a matrix frame");
      assert_fails++;
    end
  wbusy_needs_cs: assert property (@(posedge clk) disable iff (!RESET)
    mem_rsp.wbusy |-> (!ledmtx_cs || !spi_cs_n))
    else begin
      $error("wbusy high with both devices deselected");
      assert_fails++;
    end

endmodule

// ==== test/femtosoc_checker.sv ====
// compares reads, leds and serial frames with the expected values it is given; one transfer at a time
module femtosoc_checker (
  input  logic                  clk,
  input  logic                  RESET,
  input  soc_bus_pkg::mem_req_t mem_req,
  input  soc_bus_pkg::mem_rsp_t mem_rsp,
  input  logic [3:0]            leds,
  input  logic                  ledmtx_din,
  input  logic                  ledmtx_cs,
  input  logic                  ledmtx_clk,
  input  logic                  spi_mosi,
  input  logic                  spi_cs_n,
  input  logic                  spi_clk,
  input  logic                  exp_valid,
  input  logic [31:0]           exp_data,
  input  logic [3:0]            exp_leds,
  input  logic [15:0]           exp_mtx,
  input  logic [31:0]           exp_flash,
  input  int                    exp_mtx_frames,
  input  int                    exp_flash_frames,
  input  logic                  done,
  output int                    value_errs,
  output int                    other_errs
);
  timeunit 1ns;
  timeprecision 1ns;

  localparam int BUSY_LIMIT = 2000;  // far above one flash or matrix transfer

  logic rd_pend = 1'b0;
  logic led_chk = 1'b0;
  logic start_q = 1'b0;
  logic [31:0] rd_exp;
  logic [15:0] msh;
  logic [31:0] fsh;
  logic io_wr;
  int busy_run = 0;
  int mcnt = 0;
  int fcnt = 0;
  int mtx_frames = 0;
  int flash_frames = 0;

  initial begin
    value_errs = 0;
    other_errs = 0;
  end

  assign io_wr = RESET && (|mem_req.wmask) && mem_req.addr[22];

  always @(posedge clk) begin
    if (rd_pend && mem_rsp.rdata !== rd_exp) begin
      $display("mismatch at %0t: read data %h, expected %h", $time, mem_rsp.rdata, rd_exp);
      value_errs++;
    end
    if (led_chk && leds !== exp_leds) begin
      $display("mismatch at %0t: leds %h, expected %h", $time, leds, exp_leds);
      value_errs++;
    end
    if (start_q && !mem_rsp.wbusy) begin
      $display("mismatch at %0t: wbusy low right after a device start", $time);
      value_errs++;
    end
    if (RESET && !spi_cs_n && fcnt < 40 && !mem_rsp.wbusy) begin
      $display("mismatch at %0t: wbusy low while a flash transfer is running", $time);
      value_errs++;
    end
    if (RESET && mem_rsp.rbusy && fcnt < 32) begin
      $display("mismatch at %0t: rbusy high outside the flash receive phase", $time);
      value_errs++;
    end
    if (fcnt > 32 && fcnt < 40 && !mem_rsp.rbusy) begin
      $display("mismatch at %0t: rbusy low during the flash receive phase", $time);
      value_errs++;
    end
    busy_run = mem_rsp.wbusy ? busy_run + 1 : 0;
    if (busy_run == BUSY_LIMIT) begin
      $display("a device stayed busy for %0d cycles, at %0t", BUSY_LIMIT, $time);
      other_errs++;
    end
    rd_pend <= exp_valid;
    rd_exp <= exp_data;
    led_chk <= io_wr && mem_req.addr[2];  // IO_LEDS
    start_q <= io_wr && (mem_req.addr[9] || mem_req.addr[10]);  // matrix data or flash
  end

  // matrix frame bits taken at rising ledmtx_clk
  always @(posedge ledmtx_clk or posedge ledmtx_cs) begin
    if (ledmtx_cs) begin
      if (mcnt != 0) begin
        if (mcnt != 16) begin
          $display("led matrix frame had %0d clocks instead of 16", mcnt);
          other_errs++;
        end else if (msh !== exp_mtx) begin
          $display("mismatch at %0t: matrix frame %h, expected %h", $time, msh, exp_mtx);
          value_errs++;
        end
        mtx_frames++;
        mcnt = 0;
      end
    end else begin
      msh = {msh[14:0], ledmtx_din};
      mcnt++;
    end
  end

  // first 32 flash clocks carry opcode and address
  always @(posedge spi_clk or posedge spi_cs_n) begin
    if (spi_cs_n) begin
      if (fcnt != 0) begin
        if (fcnt != 40) begin
          $display("flash transfer had %0d clocks instead of 40", fcnt);
          other_errs++;
        end else if (fsh !== exp_flash) begin
          $display("mismatch at %0t: flash command %h, expected %h", $time, fsh, exp_flash);
          value_errs++;
        end
        flash_frames++;
        fcnt = 0;
      end
    end else begin
      if (fcnt < 32) fsh = {fsh[30:0], spi_mosi};
      fcnt++;
    end
  end

  always @(posedge done) begin
    if (mtx_frames != exp_mtx_frames) begin
      $display("missing led matrix frame: saw %0d of %0d", mtx_frames, exp_mtx_frames);
      other_errs++;
    end
    if (flash_frames != exp_flash_frames) begin
      $display("missing flash transfer: saw %0d of %0d", flash_frames, exp_flash_frames);
      other_errs++;
    end
    if (!spi_cs_n) begin
      $display("flash chip select still low at the end of the run");
      other_errs++;
    end
  end

endmodule

// ==== test/femtosoc_tb.sv ====
// drives the processor port directly; RAM reads use only words 0..15, one device transfer at a time
`include "femtosoc_settings.svh"

module femtosoc_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int N_RAM = 24;
  localparam int N_DEV = 3;
  localparam int N_OPS = 2 * N_RAM + 16 + 4 * N_DEV;
  localparam longint LIMIT_NS = longint'(N_OPS) * 40 * 8 * 100 * 2;  // worst-case slow bits
  localparam int K_RAM = 0;
  localparam int K_LED = 1;
  localparam int K_BTN = 2;
  localparam int K_MTX = 3;
  localparam int K_FCMD = 4;
  localparam int K_FBYTE = 5;

  logic clk = 1'b0;
  logic RESET;
  soc_bus_pkg::mem_req_t mem_req;
  soc_bus_pkg::mem_rsp_t mem_rsp;
  logic [3:0] leds;
  logic [5:0] buttons;
  logic ledmtx_din, ledmtx_cs, ledmtx_clk;
  logic spi_mosi, spi_miso, spi_cs_n, spi_clk;
  logic exp_valid, done;
  logic [31:0] exp_data, exp_flash, flash_byte;
  logic [3:0] exp_leds;
  logic [15:0] exp_mtx;
  int exp_mtx_frames, exp_flash_frames, value_errs, other_errs;
  logic [31:0] shadow [`FEMTOSOC_RAM_WORDS];  // starts X like the RAM
  int mdl_cnt;
  logic [23:0] mdl_sh;

  always #50 clk = ~clk;

  femtosoc femtosoc_inst (.clk(clk), .RESET(RESET), .mem_req(mem_req), .mem_rsp(mem_rsp),
    .leds(leds), .buttons(buttons), .ledmtx_din(ledmtx_din), .ledmtx_cs(ledmtx_cs),
    .ledmtx_clk(ledmtx_clk), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
    .spi_cs_n(spi_cs_n), .spi_clk(spi_clk));

  femtosoc_checker checker_inst (.clk(clk), .RESET(RESET), .mem_req(mem_req),
    .mem_rsp(mem_rsp), .leds(leds), .ledmtx_din(ledmtx_din), .ledmtx_cs(ledmtx_cs),
    .ledmtx_clk(ledmtx_clk), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n), .spi_clk(spi_clk),
    .exp_valid(exp_valid), .exp_data(exp_data), .exp_leds(exp_leds), .exp_mtx(exp_mtx),
    .exp_flash(exp_flash), .exp_mtx_frames(exp_mtx_frames),
    .exp_flash_frames(exp_flash_frames), .done(done), .value_errs(value_errs),
    .other_errs(other_errs));

  bind femtosoc femtosoc_properties props_inst (.clk(clk), .RESET(RESET), .mem_rsp(mem_rsp),
    .leds(leds), .ledmtx_cs(ledmtx_cs), .ledmtx_clk(ledmtx_clk), .spi_cs_n(spi_cs_n),
    .spi_clk(spi_clk));

  // expected values straight from the bus and device rules
  function automatic logic [31:0] ref_model(input int kind, input logic [31:0] a,
                                            input logic [31:0] b, input logic [3:0] m);
    logic [31:0] r;
    r = 32'b0;
    case (kind)
      K_RAM: begin
        r = a;  // old word with the masked lanes replaced
        for (int lane = 0; lane < 4; lane++) if (m[lane]) r[lane*8 +: 8] = b[lane*8 +: 8];
      end
      K_LED:   r = {28'b0, a[3:0]};
      K_BTN:   r = {26'b0, a[5:0]};
      K_MTX:   r = {16'b0, a[15:0]};
      K_FCMD:  r = {8'h03, a[23:0]};
      K_FBYTE: r = {24'b0, a[7:0] ^ 8'h5a};
      default: r = 32'b0;
    endcase
    return r;
  endfunction

  function automatic logic [23:0] io_addr(input int r);
    return 24'(1 << `FEMTOSOC_IO_PAGE_BIT) | 24'(1 << (r + 2));
  endfunction

  task automatic write_bus(input logic [23:0] a, input logic [31:0] d, input logic [3:0] m);
    @(posedge clk);
    mem_req.addr <= a;
    mem_req.wdata <= d;
    mem_req.wmask <= m;
    @(posedge clk);
    mem_req.wmask <= 4'b0;
  endtask

  // strobe, hold the address one cycle, take the data at the following edge
  task automatic read_bus(input logic [23:0] a, input logic [31:0] exp, input logic chk,
                          output logic [31:0] got);
    @(posedge clk);
    mem_req.addr <= a;
    mem_req.rstrb <= 1'b1;
    exp_valid <= chk;
    exp_data <= exp;
    @(posedge clk);
    mem_req.rstrb <= 1'b0;
    exp_valid <= 1'b0;
    @(posedge clk);
    got = mem_rsp.rdata;
  endtask

  // flash model returns a byte derived from the address it saw on mosi
  assign flash_byte = ref_model(K_FBYTE, {8'b0, mdl_sh}, 32'b0, 4'b0);
  always @(posedge spi_clk or posedge spi_cs_n) begin
    if (spi_cs_n) begin
      mdl_cnt <= 0;
    end else begin
      if (mdl_cnt < 32) mdl_sh <= {mdl_sh[22:0], spi_mosi};
      else spi_miso <= flash_byte[7 - (mdl_cnt - 32)];
      mdl_cnt <= mdl_cnt + 1;
    end
  end

  initial begin
    #(LIMIT_NS * 1ns);
    $display("timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] got;
    logic [31:0] d;
    logic [3:0] m;
    int w;
    void'($urandom(32'h7fe4_3dfb));
    RESET = 1'b0;
    mem_req = '0;
    buttons = 6'b0;
    spi_miso = 1'b0;
    exp_valid = 1'b0;
    exp_data = 32'b0;
    exp_leds = 4'b0;
    exp_mtx = 16'b0;
    exp_flash = 32'b0;
    done = 1'b0;
    exp_mtx_frames = 0;
    exp_flash_frames = 0;
    repeat (8) @(posedge clk);
    RESET <= 1'b1;
    read_bus(io_addr(soc_io_pkg::IO_LEDS), 32'b0, 1'b1, got);
    read_bus(io_addr(soc_io_pkg::IO_LEDMTX_CNTL), 32'b0, 1'b1, got);
    read_bus(io_addr(soc_io_pkg::IO_SPI_FLASH), 32'b0, 1'b1, got);
    for (int i = 0; i < N_RAM; i++) begin
      w = $urandom_range(15);
      d = $urandom;
      m = 4'($urandom_range(15, 1));
      shadow[w] = ref_model(K_RAM, shadow[w], d, m);
      write_bus(24'(w * 4), d, m);
    end
    for (w = 0; w < 16; w++) read_bus(24'(w * 4), shadow[w], 1'b1, got);
    for (int i = 0; i < 4; i++) begin
      d = $urandom;
      exp_leds <= 4'(ref_model(K_LED, d, 32'b0, 4'b0));
      write_bus(io_addr(soc_io_pkg::IO_LEDS), d, 4'hf);
      read_bus(io_addr(soc_io_pkg::IO_LEDS), ref_model(K_LED, d, 32'b0, 4'b0), 1'b1, got);
      d = $urandom;
      @(posedge clk) buttons <= d[5:0];
      read_bus(io_addr(soc_io_pkg::IO_BUTTONS), ref_model(K_BTN, d, 32'b0, 4'b0), 1'b1, got);
    end
    for (int i = 0; i < N_DEV; i++) begin
      d = $urandom;
      exp_mtx <= 16'(ref_model(K_MTX, d, 32'b0, 4'b0));
      write_bus(io_addr(soc_io_pkg::IO_LEDMTX_DAT), d, 4'hf);
      read_bus(io_addr(soc_io_pkg::IO_LEDMTX_CNTL), 32'd1, 1'b1, got);
      for (int k = 0; k < 3000 && got[0]; k++) begin
        read_bus(io_addr(soc_io_pkg::IO_LEDMTX_CNTL), 32'b0, 1'b0, got);
      end
      read_bus(io_addr(soc_io_pkg::IO_LEDMTX_CNTL), 32'b0, 1'b1, got);
      exp_mtx_frames++;
    end
    for (int i = 0; i < N_DEV; i++) begin
      d = {8'b0, 24'($urandom)};
      exp_flash <= ref_model(K_FCMD, d, 32'b0, 4'b0);
      write_bus(io_addr(soc_io_pkg::IO_SPI_FLASH), d, 4'hf);
      got = 32'h100;
      for (int k = 0; k < 3000 && got[8]; k++) begin
        read_bus(io_addr(soc_io_pkg::IO_SPI_FLASH), 32'b0, 1'b0, got);
      end
      read_bus(io_addr(soc_io_pkg::IO_SPI_FLASH), ref_model(K_FBYTE, d, 32'b0, 4'b0), 1'b1, got);
      repeat (4) @(posedge clk);
      exp_flash_frames++;
    end
    repeat (4) @(posedge clk);
    done <= 1'b1;
    repeat (2) @(posedge clk);
    $display("errors: %0d mismatch, %0d other, %0d assertion", value_errs, other_errs,
             femtosoc_inst.props_inst.assert_fails);
    if (value_errs + other_errs + femtosoc_inst.props_inst.assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
source/soc_bus_pkg.sv
source/soc_io_pkg.sv
source/femtosoc_memory.sv
source/led_matrix_tx.sv
source/spi_flash_reader.sv
source/soc_io_page.sv
source/femtosoc.sv
test/femtosoc_properties.sv
test/femtosoc_checker.sv
test/femtosoc_tb.sv

// ==== Bender.yml ====
package:
  name: femtosoc

export_include_dirs:
  - include

sources:
  - source/soc_bus_pkg.sv
  - source/soc_io_pkg.sv
  - source/femtosoc_memory.sv
  - source/led_matrix_tx.sv
  - source/spi_flash_reader.sv
  - source/soc_io_page.sv
  - source/femtosoc.sv
  - target: test
    files:
      - test/femtosoc_properties.sv
      - test/femtosoc_checker.sv
      - test/femtosoc_tb.sv
